// File: Makefile
TOP = mpfWriteChannelTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim.f
src/mpfWritePkg.sv
src/writeRequestFifo.sv
src/writeBeatTracker.sv
src/writeProtocolChecker.sv
src/writeChannelCsr.sv
src/mpfWriteChannel.sv
testbench/writeChannel_sva.sv
testbench/mpfWriteChannelTb.sv

// File: src/mpfWriteChannel.sv
`timescale 1ns/1ps
`default_nettype none

module mpfWriteChannel
    import mpfWritePkg::*;
#(
    parameter int FifoDepth = 4
)
(
    input  logic      clk,
    input  logic      reset,

    // Write beats from the requester
    input  tWriteBeat inBeat,
    input  logic      inValid,
    output logic      inReady,

    // Write beats toward memory
    output tWriteBeat outBeat,
    output logic      outValid,
    input  logic      outReady,

    // Register access
    input  tApbReq    apbReq,
    output tApbRsp    apbRsp
);

    logic        enable;
    logic        accepted;
    tWriteBeat   acceptedBeat;
    logic        eop;
    logic        packetActive;
    tClNum       nextBeatNum;
    tWriteFaults faults;
    tWriteFaults clearFaults;
    logic [31:0] errorAddress;

    // Data path, the only place beats are stored
    writeRequestFifo #(
        .FifoDepth(FifoDepth)
    ) fifo (
        .clk(clk),
        .reset(reset),
        .enable(enable),
        .inBeat(inBeat),
        .inValid(inValid),
        .inReady(inReady),
        .outBeat(outBeat),
        .outValid(outValid),
        .outReady(outReady),
        .accepted(accepted),
        .acceptedBeat(acceptedBeat)
    );

    // Beat position within the current packet
    writeBeatTracker tracker (
        .clk(clk),
        .reset(reset),
        .accepted(accepted),
        .acceptedBeat(acceptedBeat),
        .eop(eop),
        .packetActive(packetActive),
        .nextBeatNum(nextBeatNum)
    );

    // Fault detection uses the tracker state from before the beat is counted
    writeProtocolChecker protocolChecker (
        .clk(clk),
        .reset(reset),
        .accepted(accepted),
        .acceptedBeat(acceptedBeat),
        .packetActive(packetActive),
        .nextBeatNum(nextBeatNum),
        .clearFaults(clearFaults),
        .faults(faults),
        .errorAddress(errorAddress)
    );

    writeChannelCsr csr (
        .clk(clk),
        .reset(reset),
        .apbReq(apbReq),
        .apbRsp(apbRsp),
        .accepted(accepted),
        .eop(eop),
        .packetActive(packetActive),
        .faults(faults),
        .errorAddress(errorAddress),
        .enable(enable),
        .clearFaults(clearFaults)
    );

endmodule

`default_nettype wire

// File: src/mpfWritePkg.sv
`default_nettype none

package mpfWritePkg;

    // Width of the data word carried by one beat, which is one cache line slice
    localparam int DataWidth = 64;

    // Beat number inside a packet, packets span 1 to 4 lines
    typedef logic [1:0] tClNum;

    // Packet length code, number of lines minus one
    typedef logic [1:0] tClLen;

    // Header that travels with every beat
    typedef struct packed {
        // Line address of this beat
        logic [31:0] address;
        // Length code of the whole packet, repeated on each beat
        tClLen       clLen;
        // Start-of-packet marker, set only on the first beat
        logic        sop;
        // Tag carried through unchanged for the requester
        logic [15:0] mdata;
    } tWriteHdr;

    // One write beat as it enters and leaves the channel
    typedef struct packed {
        tWriteHdr               hdr;
        logic [DataWidth-1:0]   data;
    } tWriteBeat;

    // APB request side, driven by the bus master
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } tApbReq;

    // APB response side, driven by the register block
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } tApbRsp;

    // Protocol fault flags
    // The same layout serves the per-beat faults and the sticky status, and
    // sopPhase lands in status bit 1 with misaligned in bit 0
    typedef struct packed {
        logic sopPhase;
        logic misaligned;
    } tWriteFaults;

endpackage

`default_nettype wire

// File: src/writeBeatTracker.sv
`timescale 1ns/1ps
`default_nettype none

module writeBeatTracker
    import mpfWritePkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // Handshake result and beat copy from the FIFO input side
    input  logic      accepted,
    input  tWriteBeat acceptedBeat,

    // High when the presented beat is the last one of its packet
    output logic      eop,

    // High while a multi-line packet has started but not yet finished
    output logic      packetActive,
    // Beat number the next accepted beat should carry
    output tClNum     nextBeatNum
);

    // The last beat is the one whose position equals the length code
    // This looks only at the beat on the input, the caller qualifies it with accepted
    assign eop = (nextBeatNum == tClNum'(acceptedBeat.hdr.clLen));

    // Beat position state moves only on the edge that takes a beat
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            nextBeatNum  <= '0;
            packetActive <= 1'b0;
        end
        else if (accepted)
        begin
            if (eop)
            begin
                // Packet complete, wait for the next start
                nextBeatNum  <= '0;
                packetActive <= 1'b0;
            end
            else
            begin
                // More beats to come in this packet
                nextBeatNum  <= nextBeatNum + tClNum'(1);
                packetActive <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/writeChannelCsr.sv
`timescale 1ns/1ps
`default_nettype none

module writeChannelCsr
    import mpfWritePkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // APB slave port, zero wait states
    input  tApbReq      apbReq,
    output tApbRsp      apbRsp,

    // Event and status inputs from the monitors
    input  logic        accepted,
    input  logic        eop,
    input  logic        packetActive,
    input  tWriteFaults faults,
    input  logic [31:0] errorAddress,

    // Channel control
    output logic        enable,
    output tWriteFaults clearFaults
);

    // Register offsets
    localparam logic [7:0] CtrlOffset        = 8'h00;
    localparam logic [7:0] StatusOffset      = 8'h04;
    localparam logic [7:0] PacketCountOffset = 8'h08;
    localparam logic [7:0] BeatCountOffset   = 8'h0C;
    localparam logic [7:0] ErrorAddrOffset   = 8'h10;

    logic        access;
    logic        writeAccess;
    logic        addrValid;
    logic [31:0] readData;
    logic [31:0] statusWord;
    logic [31:0] packetCount;
    logic [31:0] beatCount;

    // Access phase of an APB transfer, which is also its last cycle here
    assign access      = apbReq.psel && apbReq.penable;
    assign writeAccess = access && apbReq.pwrite;

    // Status view: live packet flag in bit 8, sticky faults in the low bits
    assign statusWord = {23'b0, packetActive, 6'b0, faults};

    // Write-one-to-clear on the status register acts on the completing edge
    assign clearFaults = (writeAccess && (apbReq.paddr == StatusOffset))
                       ? tWriteFaults'(apbReq.pwdata[1:0])
                       : '0;

    // Read mux and address check
    always_comb
    begin
        readData  = '0;
        addrValid = 1'b1;
        case (apbReq.paddr)
            CtrlOffset:        readData = {31'b0, enable};
            StatusOffset:      readData = statusWord;
            PacketCountOffset: readData = packetCount;
            BeatCountOffset:   readData = beatCount;
            ErrorAddrOffset:   readData = errorAddress;
            default:           addrValid = 1'b0;
        endcase
    end

    always_comb
    begin
        apbRsp.prdata  = (apbReq.psel && !apbReq.pwrite) ? readData : '0;
        // No wait states ever
        apbRsp.pready  = 1'b1;
        apbRsp.pslverr = access && !addrValid;
    end

    // Control register, only bit 0 is implemented
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            enable <= 1'b0;
        end
        else if (writeAccess && (apbReq.paddr == CtrlOffset))
        begin
            enable <= apbReq.pwdata[0];
        end
    end

    // Traffic counters, they wrap silently
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            packetCount <= '0;
            beatCount   <= '0;
        end
        else if (accepted)
        begin
            beatCount <= beatCount + 32'd1;
            // A packet counts once its last beat is in
            if (eop)
            begin
                packetCount <= packetCount + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/writeProtocolChecker.sv
`timescale 1ns/1ps
`default_nettype none

module writeProtocolChecker
    import mpfWritePkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // Beat taken by the FIFO on this edge
    input  logic        accepted,
    input  tWriteBeat   acceptedBeat,

    // Position state from the beat tracker, valid before this beat is counted
    input  logic        packetActive,
    input  tClNum       nextBeatNum,

    // Per-bit clear request from the register block
    input  tWriteFaults clearFaults,

    // Sticky fault flags and the address of the first faulting beat
    output tWriteFaults faults,
    output logic [31:0] errorAddress
);

    // Faults found on the beat presented this cycle
    tWriteFaults beatFaults;
    // Faults found on a beat that is really accepted
    tWriteFaults newFaults;
    // Sticky bits that survive this cycle's clear
    tWriteFaults faultsKept;
    // Low address bits of the beat, sized like a beat number
    tClNum       lowAddress;

    always_comb
    begin
        lowAddress = tClNum'(acceptedBeat.hdr.address[$bits(tClNum)-1:0]);

        // A start marker is expected exactly when no packet is open
        beatFaults.sopPhase = (acceptedBeat.hdr.sop != !packetActive);

        // The start of a packet must be aligned to its total size, so the
        // address bits covered by the length code must count up with the beat
        beatFaults.misaligned =
            (((lowAddress ^ nextBeatNum) & tClNum'(acceptedBeat.hdr.clLen)) != '0);

        newFaults  = accepted ? beatFaults : '0;
        faultsKept = faults & ~clearFaults;
    end

    // A fault seen in the same cycle as a clear survives the clear
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            faults <= '0;
        end
        else
        begin
            faults <= faultsKept | newFaults;
        end
    end

    // Address capture only happens when nothing is pending, so the first
    // faulting beat since the last clear is the one that is kept
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            errorAddress <= '0;
        end
        else if ((newFaults != '0) && (faultsKept == '0))
        begin
            errorAddress <= acceptedBeat.hdr.address;
        end
    end

endmodule

`default_nettype wire

// File: src/writeRequestFifo.sv
`timescale 1ns/1ps
`default_nettype none

module writeRequestFifo
    import mpfWritePkg::*;
#(
    parameter int FifoDepth = 4
)
(
    input  logic      clk,
    input  logic      reset,
    input  logic      enable,

    // Upstream side
    input  tWriteBeat inBeat,
    input  logic      inValid,
    output logic      inReady,

    // Downstream side
    output tWriteBeat outBeat,
    output logic      outValid,
    input  logic      outReady,

    // Copy of each taken beat for the monitors
    output logic      accepted,
    output tWriteBeat acceptedBeat
);

    localparam int PtrWidth   = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
    localparam int CountWidth = $clog2(FifoDepth + 1);

    // Beat storage, written at wrPtr and read at rdPtr
    tWriteBeat             storage [FifoDepth];
    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] count;
    logic                  full;
    logic                  popped;

    // Wrap a pointer at the depth
    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        if (ptr == PtrWidth'(FifoDepth - 1))
        begin
            return '0;
        end
        return ptr + PtrWidth'(1);
    endfunction

    assign full = (count == CountWidth'(FifoDepth));

    // Readiness does not look at the output side, so a full FIFO stalls the
    // input for a cycle even when the head leaves at the same edge
    assign inReady  = enable && !full;
    assign accepted = inValid && inReady;
    assign acceptedBeat = inBeat;

    // Head of the queue is shown straight from storage
    assign outValid = (count != '0);
    assign outBeat  = storage[rdPtr];
    assign popped   = outValid && outReady;

    always_ff @(posedge clk)
    begin
        if (accepted)
        begin
            storage[wrPtr] <= inBeat;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (accepted)
            begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (popped)
            begin
                rdPtr <= nextPtr(rdPtr);
            end
            // Occupancy stays put when a push and a pop meet
            if (accepted && !popped)
            begin
                count <= count + CountWidth'(1);
            end
            else if (popped && !accepted)
            begin
                count <= count - CountWidth'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/mpfWriteChannelTb.sv
`timescale 1ns/1ps
`default_nettype none

module mpfWriteChannelTb
    import mpfWritePkg::*;
();

    // The whole run takes a few hundred cycles, so ten times that leaves a wide margin
    localparam int CycleLimit = 4000;

    logic      clk;
    logic      reset;
    tWriteBeat inBeat;
    logic      inValid;
    logic      inReady;
    tWriteBeat outBeat;
    logic      outValid;
    logic      outReady;
    tApbReq    apbReq;
    tApbRsp    apbRsp;

    int        seed = 82144;
    int        errorCount = 0;
    int        testCount = 0;
    int        failedTests = 0;
    int        cycleCount = 0;
    // Beats sent and still to come out, oldest first
    tWriteBeat expectedQ[$];

    mpfWriteChannel #(
        .FifoDepth(4)
    ) UUT (
        .clk(clk),
        .reset(reset),
        .inBeat(inBeat),
        .inValid(inValid),
        .inReady(inReady),
        .outBeat(outBeat),
        .outValid(outValid),
        .outReady(outReady),
        .apbReq(apbReq),
        .apbRsp(apbRsp)
    );

    always #50 clk = ~clk;

    // Run limit
    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CycleLimit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic checkBeat(input tWriteBeat got, input tWriteBeat expected, input string what);
        if (got !== expected)
        begin
            errorCount++;
            $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, expected);
        end
    endtask

    task automatic checkWord(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
        if (got !== expected)
        begin
            errorCount++;
            $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, expected);
        end
    endtask

    task automatic checkFaults(input tWriteFaults got, input tWriteFaults expected,
                               input string what);
        if (got !== expected)
        begin
            errorCount++;
            $display("Fail at %0t ns: %s, got sopPhase %b misaligned %b, expected %b %b",
                     $time, what, got.sopPhase, got.misaligned,
                     expected.sopPhase, expected.misaligned);
        end
    endtask

    function automatic tWriteFaults faultSet(input logic sopPhase, input logic misaligned);
        tWriteFaults f;
        f.sopPhase   = sopPhase;
        f.misaligned = misaligned;
        return f;
    endfunction

    // Setup phase, then one access phase since pready is always high
    task automatic apbWrite(input logic [7:0] address, input logic [31:0] value);
        @(negedge clk);
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = 1'b1;
        apbReq.paddr   = address;
        apbReq.pwdata  = value;
        @(negedge clk);
        apbReq.penable = 1'b1;
        #10;
        checkWord({31'b0, apbRsp.pready}, 32'd1, "pready in a write access phase");
        @(negedge clk);
        apbReq = '0;
    endtask

    task automatic apbRead(input logic [7:0] address, output logic [31:0] value,
                           output logic slvErr);
        @(negedge clk);
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = 1'b0;
        apbReq.paddr   = address;
        apbReq.pwdata  = '0;
        @(negedge clk);
        apbReq.penable = 1'b1;
        // Read data is combinational from the request, so let it settle first
        #10;
        value  = apbRsp.prdata;
        slvErr = apbRsp.pslverr;
        checkWord({31'b0, apbRsp.pready}, 32'd1, "pready in a read access phase");
        @(negedge clk);
        apbReq = '0;
    endtask

    task automatic expectRegister(input logic [7:0] address, input logic [31:0] expected,
                                  input string what);
        logic [31:0] value;
        logic        slvErr;
        apbRead(address, value, slvErr);
        checkWord(value, expected, what);
        checkWord({31'b0, slvErr}, 32'd0, {what, " pslverr"});
    endtask

    task automatic expectFaults(input tWriteFaults expected, input string what);
        logic [31:0] status;
        logic        slvErr;
        apbRead(8'h04, status, slvErr);
        checkFaults(tWriteFaults'(status[1:0]), expected, what);
        // No packet is open when this is read, so bit 8 is clear too
        checkWord(status & 32'hFFFF_FFFC, 32'd0, {what, " upper status bits"});
    endtask

    // Holds the beat until inReady, which is settled at the falling edge
    task automatic driveBeat(input tWriteBeat beat);
        @(negedge clk);
        inBeat  = beat;
        inValid = 1'b1;
        while (!inReady)
        begin
            @(negedge clk);
        end
        // Taken at the rising edge in between
        @(negedge clk);
        inValid = 1'b0;
    endtask

    // Beat i of a packet carries line address start + i and the same length code
    task automatic sendPacket(input logic [31:0] startAddress, input int lines,
                              input logic sopEveryBeat, input logic [15:0] tag);
        tWriteBeat beat;
        for (int i = 0; i < lines; i++)
        begin
            beat.hdr.address = startAddress + 32'(i);
            beat.hdr.clLen   = tClLen'(lines - 1);
            beat.hdr.sop     = (i == 0) || sopEveryBeat;
            beat.hdr.mdata   = tag;
            beat.data        = {32'($random(seed)), 32'($random(seed))};
            expectedQ.push_back(beat);
            driveBeat(beat);
        end
    endtask

    task automatic collectBeat(output tWriteBeat beat);
        @(negedge clk);
        while (!outValid)
        begin
            @(negedge clk);
        end
        beat     = outBeat;
        outReady = 1'b1;
        @(negedge clk);
        outReady = 1'b0;
    endtask

    task automatic compareBeats(input int count, input string what);
        tWriteBeat got;
        for (int i = 0; i < count; i++)
        begin
            collectBeat(got);
            if (expectedQ.size() == 0)
            begin
                errorCount++;
                $display("A beat came out at %0t ns when none was expected", $time);
            end
            else
            begin
                checkBeat(got, expectedQ.pop_front(), what);
            end
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testCount++;
        if (expectedQ.size() != 0)
        begin
            errorCount++;
            $display("%0d sent beats never came out", expectedQ.size());
            expectedQ.delete();
        end
        if (errorCount == errorsBefore)
        begin
            $display("Test %0d %s: ok", testCount, name);
        end
        else
        begin
            failedTests++;
            $display("Test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
        end
    endtask

    task automatic testResetValues();
        int errorsBefore;
        errorsBefore = errorCount;
        checkWord({31'b0, inReady}, 32'd0, "inReady after reset");
        checkWord({31'b0, outValid}, 32'd0, "outValid after reset");
        expectRegister(8'h00, 32'd0, "control after reset");
        expectRegister(8'h04, 32'd0, "status after reset");
        expectRegister(8'h08, 32'd0, "packet count after reset");
        expectRegister(8'h0C, 32'd0, "beat count after reset");
        finishTest("reset values", errorsBefore);
    endtask

    task automatic testSingleLines();
        int errorsBefore;
        errorsBefore = errorCount;
        apbWrite(8'h00, 32'd1);
        fork
            begin
                for (int i = 0; i < 4; i++)
                begin
                    sendPacket(32'h40 + 32'(i), 1, 1'b0, 16'h0100 + 16'(i));
                end
            end
            compareBeats(4, "single-line beat");
        join
        expectRegister(8'h08, 32'd4, "packet count");
        expectRegister(8'h0C, 32'd4, "beat count");
        expectRegister(8'h04, 32'd0, "status");
        finishTest("single-line writes", errorsBefore);
    endtask

    task automatic testBackPressure();
        int          errorsBefore;
        logic [31:0] packetsBefore;
        logic [31:0] beatsBefore;
        logic [31:0] statusInside;
        logic        slvErr;
        errorsBefore = errorCount;
        apbRead(8'h08, packetsBefore, slvErr);
        apbRead(8'h0C, beatsBefore, slvErr);
        // outReady stays low, so the four beats fill the FIFO exactly
        // The status read lands after the first beat, while the packet is still open
        fork
            sendPacket(32'h100, 4, 1'b0, 16'h0200);
            begin
                apbRead(8'h04, statusInside, slvErr);
                checkWord(statusInside, 32'h0000_0100, "status inside an open packet");
            end
        join
        repeat (5)
        begin
            @(negedge clk);
            checkWord({31'b0, inReady}, 32'd0, "inReady with a full FIFO");
            checkWord({31'b0, outValid}, 32'd1, "outValid with a full FIFO");
        end
        compareBeats(4, "back-pressured beat");
        expectRegister(8'h08, packetsBefore + 32'd1, "packet count after 4-line packet");
        expectRegister(8'h0C, beatsBefore + 32'd4, "beat count after 4-line packet");
        expectFaults(faultSet(1'b0, 1'b0), "faults after aligned packet");
        finishTest("back-pressure", errorsBefore);
    endtask

    task automatic testSopPhase();
        int errorsBefore;
        errorsBefore = errorCount;
        // The second beat repeats the start marker inside an open packet
        sendPacket(32'h200, 2, 1'b1, 16'h0300);
        compareBeats(2, "beat with extra sop");
        expectFaults(faultSet(1'b1, 1'b0), "faults after extra sop");
        expectRegister(8'h10, 32'h201, "error address of extra sop");
        apbWrite(8'h04, 32'h3);
        expectRegister(8'h04, 32'd0, "status after clear");
        finishTest("sop phase fault", errorsBefore);
    endtask

    task automatic testMisaligned();
        int errorsBefore;
        errorsBefore = errorCount;
        // A 4-line packet must start on a 4-line boundary
        sendPacket(32'h302, 4, 1'b0, 16'h0400);
        compareBeats(4, "misaligned beat");
        expectFaults(faultSet(1'b0, 1'b1), "faults after misaligned packet");
        expectRegister(8'h10, 32'h302, "error address of misaligned packet");
        apbWrite(8'h04, 32'h3);
        expectRegister(8'h04, 32'd0, "status after clear");
        finishTest("misaligned packet", errorsBefore);
    endtask

    task automatic testDisable();
        int          errorsBefore;
        tWriteBeat   beat;
        logic [31:0] beatsBefore;
        logic [31:0] beatsWhileOff;
        logic        slvErr;
        errorsBefore = errorCount;
        apbRead(8'h0C, beatsBefore, slvErr);
        apbWrite(8'h00, 32'd0);
        beat.hdr.address = 32'h400;
        beat.hdr.clLen   = tClLen'(0);
        beat.hdr.sop     = 1'b1;
        beat.hdr.mdata   = 16'h0500;
        beat.data        = {32'($random(seed)), 32'($random(seed))};
        expectedQ.push_back(beat);
        fork
            driveBeat(beat);
            begin
                repeat (8)
                begin
                    @(negedge clk);
                    checkWord({31'b0, inReady}, 32'd0, "inReady while disabled");
                    checkWord({31'b0, outValid}, 32'd0, "outValid while disabled");
                end
                apbRead(8'h0C, beatsWhileOff, slvErr);
                checkWord(beatsWhileOff, beatsBefore, "beat count while disabled");
                apbWrite(8'h00, 32'd1);
            end
        join
        compareBeats(1, "beat after re-enable");
        expectRegister(8'h0C, beatsBefore + 32'd1, "beat count after re-enable");
        finishTest("enable gating", errorsBefore);
    endtask

    task automatic testBadOffset();
        int          errorsBefore;
        logic [31:0] value;
        logic        slvErr;
        errorsBefore = errorCount;
        apbRead(8'h20, value, slvErr);
        checkWord(value, 32'd0, "read data of unmapped offset");
        checkWord({31'b0, slvErr}, 32'd1, "pslverr of unmapped offset");
        finishTest("unmapped offset", errorsBefore);
    endtask

    initial
    begin
        clk      = 1'b0;
        reset    = 1'b1;
        inBeat   = '0;
        inValid  = 1'b0;
        outReady = 1'b0;
        apbReq   = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        testResetValues();
        testSingleLines();
        testBackPressure();
        testSopPhase();
        testMisaligned();
        testDisable();
        testBadOffset();

        // Failed assertions in the bound checker count as errors too
        errorCount = errorCount + UUT.assertions.failures;
        $display("Summary: %0d tests, %0d failed, %0d errors",
                 testCount, failedTests, errorCount);
        if (errorCount == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/writeChannel_sva.sv
`timescale 1ns/1ps
`default_nettype none

module writeChannelAssertions
    import mpfWritePkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      inReady,
    input  tWriteBeat outBeat,
    input  logic      outValid,
    input  logic      outReady,
    input  logic      enable,
    input  logic      packetActive,
    input  tClNum     nextBeatNum
);

    int failures = 0;

    // A packet is open exactly when the tracker expects a later beat
    activeMatchesBeatNum: assert property (@(posedge clk) disable iff (reset)
        packetActive == (nextBeatNum != '0))
    else
    begin
        failures++;
        $error("packetActive disagrees with nextBeatNum");
    end

    // A stalled output holds its beat
    outputHeldWhileStalled: assert property (@(posedge clk) disable iff (reset)
        (outValid && !outReady) |=> (outValid && $stable(outBeat)))
    else
    begin
        failures++;
        $error("output beat changed or vanished while outReady was low");
    end

    // A disabled channel takes nothing
    noReadyWhileDisabled: assert property (@(posedge clk) disable iff (reset)
        !enable |-> !inReady)
    else
    begin
        failures++;
        $error("inReady was high while the channel was disabled");
    end

endmodule

bind mpfWriteChannel writeChannelAssertions assertions (
    .clk(clk),
    .reset(reset),
    .inReady(inReady),
    .outBeat(outBeat),
    .outValid(outValid),
    .outReady(outReady),
    .enable(enable),
    .packetActive(packetActive),
    .nextBeatNum(nextBeatNum)
);

`default_nettype wire
